//--- files.f
src/range_pkg.sv
src/zone_regfile.sv
src/zone_detector.sv
src/zone_event_collector.sv
src/range_monitor_top.sv
testbench/range_monitor_assert.sv
testbench/range_monitor_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the range monitor testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    -f files.f \
    --top-module range_monitor_tb \
    -Mdir obj_dir \
    -o Vrange_monitor_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vrange_monitor_tb +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST OK" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $LOG"
    exit 1
fi

//--- src/range_monitor_top.sv
//****************************************************************************
// range monitor top level
//****************************************************************************

`timescale 1ns/1ps

module range_monitor_top import range_pkg::*; #(
    parameter int ZONES = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  logic [7:0]       paddr,
    input  logic [31:0]      pwdata,
    output logic [31:0]      prdata,
    input  sample_t          sample_in,
    output logic [ZONES-1:0] zone_flags,
    output logic             irq
);

    zone_cfg_t [ZONES-1:0] zone_cfg;
    logic [ZONES-1:0]      irq_en;
    logic [ZONES-1:0]      status_clr;
    logic [ZONES-1:0]      status;

    // APB registers
    zone_regfile #(
        .ZONES(ZONES)
    ) u_regfile (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .zone_cfg   (zone_cfg),
        .irq_en     (irq_en),
        .status_clr (status_clr),
        .status     (status),
        .zone_flags (zone_flags)
    );

    // one detector per zone, all see the same sample
    for (genvar i = 0; i < ZONES; i++) begin : g_zone
        zone_detector u_detector (
            .clk       (clk),
            .rst       (rst),
            .sample_in (sample_in),
            .cfg       (zone_cfg[i]),
            .hit       (zone_flags[i])
        );
    end

    // status bits and interrupt
    zone_event_collector #(
        .ZONES(ZONES)
    ) u_collector (
        .clk        (clk),
        .rst        (rst),
        .zone_flags (zone_flags),
        .irq_en     (irq_en),
        .status_clr (status_clr),
        .status     (status),
        .irq        (irq)
    );

endmodule

//--- src/range_pkg.sv
//****************************************************************************
// range monitor shared types
//****************************************************************************

package range_pkg;

    // sample width, fixed so the structs below have a known size
    localparam int DATA_W = 8;

    // per-zone test mode
    typedef enum logic [1:0] {
        ZONE_OFF     = 2'd0,
        ZONE_INSIDE  = 2'd1,
        ZONE_OUTSIDE = 2'd2
    } zone_mode_e;

    // one zone's window and mode
    typedef struct packed {
        logic [DATA_W-1:0] lower;
        logic [DATA_W-1:0] upper;
        zone_mode_e        mode;
    } zone_cfg_t;

    // one sample on the input stream
    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] data;
    } sample_t;

    // APB byte offsets
    // zone i config lives at ZONE_CFG_BASE + 4*i
    localparam logic [7:0] ZONE_CFG_BASE = 8'h00;
    localparam logic [7:0] IRQ_EN_ADDR   = 8'h40;
    localparam logic [7:0] STATUS_ADDR   = 8'h44;
    localparam logic [7:0] FLAGS_ADDR    = 8'h48;

endpackage

//--- src/zone_detector.sv
//****************************************************************************
// single zone window detector
//****************************************************************************

`timescale 1ns/1ps

module zone_detector import range_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  sample_t   sample_in,
    input  zone_cfg_t cfg,
    output logic      hit
);

    logic ge_lower;
    logic le_upper;
    logic in_win;
    logic hit_next;

    // two bound compares, lower > upper leaves the window empty
    assign ge_lower = (sample_in.data >= cfg.lower);
    assign le_upper = (sample_in.data <= cfg.upper);
    assign in_win   = ge_lower & le_upper;

    // apply zone mode
    always_comb begin
        case (cfg.mode)
            ZONE_INSIDE:  hit_next = in_win;
            ZONE_OUTSIDE: hit_next = ~in_win;
            default:      hit_next = 1'b0;
        endcase
    end

    // flag only moves on a valid sample
    always_ff @(posedge clk) begin
        if (rst) begin
            hit <= 1'b0;
        end else if (sample_in.valid) begin
            hit <= hit_next;
        end
    end

endmodule

//--- src/zone_event_collector.sv
//****************************************************************************
// sticky status and interrupt
//****************************************************************************

`timescale 1ns/1ps

module zone_event_collector #(
    parameter int ZONES = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [ZONES-1:0] zone_flags,
    input  logic [ZONES-1:0] irq_en,
    input  logic [ZONES-1:0] status_clr,
    output logic [ZONES-1:0] status,
    output logic             irq
);

    logic [ZONES-1:0] flags_q;
    logic [ZONES-1:0] flag_rise;

    // previous flags for edge detect
    always_ff @(posedge clk) begin
        if (rst) begin
            flags_q <= '0;
        end else begin
            flags_q <= zone_flags;
        end
    end

    assign flag_rise = zone_flags & ~flags_q;

    // set beats clear when both hit the same edge
    always_ff @(posedge clk) begin
        if (rst) begin
            status <= '0;
        end else begin
            status <= (status & ~status_clr) | flag_rise;
        end
    end

    // level interrupt from enabled zones
    assign irq = |(status & irq_en);

endmodule

//--- src/zone_regfile.sv
//****************************************************************************
// zone register block
//****************************************************************************

`timescale 1ns/1ps

module zone_regfile import range_pkg::*; #(
    parameter int ZONES = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [7:0]             paddr,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output zone_cfg_t [ZONES-1:0]  zone_cfg,
    output logic [ZONES-1:0]       irq_en,
    output logic [ZONES-1:0]       status_clr,
    input  logic [ZONES-1:0]       status,
    input  logic [ZONES-1:0]       zone_flags
);

    logic       wr_en;
    logic       rd_en;
    logic [7:0] cfg_off;
    logic [5:0] cfg_idx;
    logic       cfg_sel;

    // mode field decode, the unused code 3 falls back to off
    function automatic zone_mode_e decode_mode(input logic [1:0] raw);
        zone_mode_e mode;
        case (raw)
            2'd1:    mode = ZONE_INSIDE;
            2'd2:    mode = ZONE_OUTSIDE;
            default: mode = ZONE_OFF;
        endcase
        return mode;
    endfunction

    // access phase qualifiers
    assign wr_en = psel & penable & pwrite;
    assign rd_en = psel & penable & ~pwrite;

    // zone config window decode
    assign cfg_off = paddr - ZONE_CFG_BASE;
    assign cfg_idx = cfg_off[7:2];
    assign cfg_sel = (cfg_off[1:0] == 2'b00) && (int'(cfg_idx) < ZONES)
                     && (paddr >= ZONE_CFG_BASE);

    // zone bounds and modes
    always_ff @(posedge clk) begin
        if (rst) begin
            zone_cfg <= '0;
        end else if (wr_en && cfg_sel) begin
            for (int i = 0; i < ZONES; i++) begin
                if (int'(cfg_idx) == i) begin
                    zone_cfg[i].lower <= pwdata[7:0];
                    zone_cfg[i].upper <= pwdata[15:8];
                    zone_cfg[i].mode  <= decode_mode(pwdata[17:16]);
                end
            end
        end
    end

    // interrupt enable mask
    always_ff @(posedge clk) begin
        if (rst) begin
            irq_en <= '0;
        end else if (wr_en && paddr == IRQ_EN_ADDR) begin
            irq_en <= pwdata[ZONES-1:0];
        end
    end

    // write-one-to-clear pulse, lands on the access edge
    always_comb begin
        status_clr = '0;
        if (wr_en && paddr == STATUS_ADDR) begin
            status_clr = pwdata[ZONES-1:0];
        end
    end

    // read mux, unmapped offsets return zero
    always_comb begin
        prdata = '0;
        if (rd_en) begin
            if (cfg_sel) begin
                for (int i = 0; i < ZONES; i++) begin
                    if (int'(cfg_idx) == i) begin
                        prdata[7:0]   = zone_cfg[i].lower;
                        prdata[15:8]  = zone_cfg[i].upper;
                        prdata[17:16] = zone_cfg[i].mode;
                    end
                end
            end else if (paddr == IRQ_EN_ADDR) begin
                prdata[ZONES-1:0] = irq_en;
            end else if (paddr == STATUS_ADDR) begin
                prdata[ZONES-1:0] = status;
            end else if (paddr == FLAGS_ADDR) begin
                // live detector outputs
                prdata[ZONES-1:0] = zone_flags;
            end
        end
    end

endmodule

//--- testbench/range_monitor_assert.sv
//****************************************************************************
// range monitor protocol checks
//****************************************************************************

`timescale 1ns/1ps

module range_monitor_assert import range_pkg::*; #(
    parameter int ZONES = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  sample_t          sample_in,
    input  logic [ZONES-1:0] zone_flags,
    input  logic [ZONES-1:0] status,
    input  logic [ZONES-1:0] irq_en,
    input  logic             irq
);

    int fail_count = 0;

    // flags only move at the edge that takes a valid sample
    flags_hold: assert property (@(posedge clk) disable iff (rst)
        !$past(sample_in.valid) |-> $stable(zone_flags))
        else begin
            $error("zone_flags changed without a valid sample");
            fail_count++;
        end

    // irq rises only after a new hit in an enabled zone or a mask change
    irq_rise_cause: assert property (@(posedge clk) disable iff (rst)
        $rose(irq) |-> (irq_en != $past(irq_en))
                       || |($past(zone_flags) & ~$past(zone_flags, 2) & irq_en))
        else begin
            $error("irq rose without a new enabled hit or a mask change");
            fail_count++;
        end

    // everything idle once reset has been seen
    reset_idle: assert property (@(posedge clk)
        rst |=> (zone_flags == '0) && (status == '0) && !irq)
        else begin
            $error("flags, status or irq not cleared by reset");
            fail_count++;
        end

endmodule

bind range_monitor_top range_monitor_assert #(
    .ZONES(ZONES)
) u_assert (
    .clk        (clk),
    .rst        (rst),
    .sample_in  (sample_in),
    .zone_flags (zone_flags),
    .status     (status),
    .irq_en     (irq_en),
    .irq        (irq)
);

//--- testbench/range_monitor_tb.sv
//****************************************************************************
// range monitor testbench
//****************************************************************************

`timescale 1ns/1ps

module range_monitor_tb import range_pkg::*; ();

    localparam int ZONES          = 4;
    localparam int CLK_PERIOD     = 40;
    localparam int RAND_SAMPLES   = 200;
    // all seven tests take about 730 cycles
    localparam int TEST_CYCLES    = 800;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    logic             clk;
    logic             rst;
    logic             psel;
    logic             penable;
    logic             pwrite;
    logic [7:0]       paddr;
    logic [31:0]      pwdata;
    logic [31:0]      prdata;
    sample_t          sample_in;
    logic [ZONES-1:0] zone_flags;
    logic             irq;

    // reference model state
    logic [7:0]       exp_lower [ZONES];
    logic [7:0]       exp_upper [ZONES];
    logic [1:0]       exp_mode  [ZONES];
    logic [ZONES-1:0] exp_flags;
    logic [ZONES-1:0] exp_status;
    logic [ZONES-1:0] exp_irq_en;
    logic [31:0]      rd_data;
    logic [31:0]      lcg_state;
    int               checks;
    int               errors;
    int               cycle_count = 0;

    range_monitor_top #(
        .ZONES(ZONES)
    ) uut (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .sample_in  (sample_in),
        .zone_flags (zone_flags),
        .irq        (irq)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("timeout after %0d cycles, the tests did not finish", cycle_count);
        $display("TEST FAILED");
        $finish;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // mode code 3 is kept as off
    function automatic logic [1:0] stored_mode(input logic [1:0] raw);
        return (raw == 2'd3) ? 2'd0 : raw;
    endfunction

    // hit rule for one zone
    function automatic logic zone_hits(input logic [7:0] lo, input logic [7:0] hi,
                                       input logic [1:0] mode, input logic [7:0] data);
        logic in_window;
        logic result;
        in_window = (data >= lo) && (data <= hi);
        case (mode)
            ZONE_INSIDE:  result = in_window;
            ZONE_OUTSIDE: result = !in_window;
            default:      result = 1'b0;
        endcase
        return result;
    endfunction

    function automatic logic [31:0] cfg_word(input int idx);
        return {14'b0, exp_mode[idx], exp_upper[idx], exp_lower[idx]};
    endfunction

    // model state right after reset
    task automatic clear_model();
        exp_flags  = '0;
        exp_status = '0;
        exp_irq_en = '0;
        for (int i = 0; i < ZONES; i++) begin
            exp_lower[i] = 8'h00;
            exp_upper[i] = 8'h00;
            exp_mode[i]  = 2'd0;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("Mismatch %s expected %h got %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        #2;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #2;
        penable = 1'b1;
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic read_check(input logic [7:0] addr, input logic [31:0] expected);
        @(posedge clk);
        #2;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #2;
        penable = 1'b1;
        // prdata is combinational in the access phase
        @(negedge clk);
        rd_data = prdata;
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        check_value("prdata", expected, rd_data);
    endtask

    task automatic write_zone(input int idx, input logic [7:0] lo, input logic [7:0] hi,
                              input logic [1:0] raw_mode);
        apb_write(ZONE_CFG_BASE + 8'(4 * idx), {14'b0, raw_mode, hi, lo});
        exp_lower[idx] = lo;
        exp_upper[idx] = hi;
        exp_mode[idx]  = stored_mode(raw_mode);
    endtask

    task automatic write_irq_en(input logic [ZONES-1:0] mask);
        apb_write(IRQ_EN_ADDR, 32'(mask));
        exp_irq_en = mask;
    endtask

    task automatic clear_status(input logic [ZONES-1:0] mask);
        apb_write(STATUS_ADDR, 32'(mask));
        exp_status = exp_status & ~mask;
    endtask

    // one stream cycle and a flag compare against the model
    task automatic send_sample(input logic valid, input logic [7:0] data);
        logic [ZONES-1:0] next_flags;
        next_flags = exp_flags;
        if (valid) begin
            for (int i = 0; i < ZONES; i++) begin
                next_flags[i] = zone_hits(exp_lower[i], exp_upper[i], exp_mode[i], data);
            end
        end
        @(posedge clk);
        #2;
        sample_in.valid = valid;
        sample_in.data  = data;
        @(posedge clk);
        #2;
        sample_in.valid = 1'b0;
        exp_status = exp_status | (next_flags & ~exp_flags);
        exp_flags  = next_flags;
        check_value("zone_flags", 32'(exp_flags), 32'(zone_flags));
    endtask

    task automatic sample_and_read(input logic [7:0] data);
        send_sample(1'b1, data);
        read_check(FLAGS_ADDR, 32'(exp_flags));
    endtask

    // status lands one cycle after the flag
    task automatic check_irq();
        @(posedge clk);
        #2;
        check_value("irq", 32'(|(exp_status & exp_irq_en)), 32'(irq));
    endtask

    task automatic report_test(input string name, input int err_mark);
        $display("%s: done, %0d errors", name, errors - err_mark);
    endtask

    initial begin
        int          err_mark;
        logic [31:0] r;
        rst       = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = 8'h00;
        pwdata    = 32'h0;
        sample_in = '0;
        lcg_state = 32'h58d28669;
        checks    = 0;
        errors    = 0;
        clear_model();
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;

        // register readback with the reserved mode code on zone 3
        err_mark = errors;
        for (int i = 0; i < ZONES; i++) begin
            write_zone(i, 8'(16 * i + 1), 8'(16 * i + 8), 2'(i));
        end
        write_irq_en(ZONES'(32'h5a5a));
        for (int i = 0; i < ZONES; i++) begin
            read_check(ZONE_CFG_BASE + 8'(4 * i), cfg_word(i));
        end
        read_check(IRQ_EN_ADDR, 32'(exp_irq_en));
        read_check(ZONE_CFG_BASE + 8'(4 * ZONES), 32'h0);
        read_check(8'h02, 32'h0);
        read_check(8'h4c, 32'h0);
        read_check(8'hfc, 32'h0);
        write_irq_en('0);
        report_test("register readback", err_mark);

        // window edges in inside mode
        err_mark = errors;
        write_zone(0, 8'h40, 8'h60, 2'd1);
        write_zone(1, 8'h20, 8'h30, 2'd1);
        write_zone(2, 8'h50, 8'h50, 2'd1);
        write_zone(3, 8'h00, 8'hff, 2'd0);
        sample_and_read(8'h3f);
        sample_and_read(8'h40);
        sample_and_read(8'h60);
        sample_and_read(8'h61);
        report_test("inside mode", err_mark);

        // outside, off, and an empty window
        err_mark = errors;
        write_zone(0, 8'h40, 8'h60, 2'd2);
        write_zone(1, 8'h00, 8'hff, 2'd0);
        write_zone(2, 8'h80, 8'h20, 2'd1);
        write_zone(3, 8'h00, 8'hff, 2'd2);
        sample_and_read(8'h10);
        sample_and_read(8'h50);
        sample_and_read(8'h80);
        sample_and_read(8'h20);
        sample_and_read(8'hff);
        sample_and_read(8'h00);
        report_test("outside and off modes", err_mark);

        // sticky status and write-one-to-clear
        err_mark = errors;
        write_zone(0, 8'h10, 8'h1f, 2'd1);
        write_zone(1, 8'h80, 8'h8f, 2'd1);
        write_zone(2, 8'h00, 8'hff, 2'd0);
        write_zone(3, 8'h00, 8'hff, 2'd0);
        send_sample(1'b1, 8'h00);
        clear_status('1);
        read_check(STATUS_ADDR, 32'(exp_status));
        send_sample(1'b1, 8'h15);
        read_check(STATUS_ADDR, 32'(exp_status));
        send_sample(1'b1, 8'h00);
        read_check(STATUS_ADDR, 32'(exp_status));
        send_sample(1'b1, 8'h85);
        read_check(STATUS_ADDR, 32'(exp_status));
        clear_status(ZONES'(1));
        read_check(STATUS_ADDR, 32'(exp_status));
        clear_status(ZONES'(2));
        read_check(STATUS_ADDR, 32'(exp_status));
        report_test("sticky status", err_mark);

        // interrupt masking
        err_mark = errors;
        write_irq_en(ZONES'(1));
        send_sample(1'b1, 8'h00);
        send_sample(1'b1, 8'h85);
        check_irq();
        send_sample(1'b1, 8'h15);
        check_irq();
        clear_status(ZONES'(1));
        check_irq();
        write_irq_en(ZONES'(2));
        check_irq();
        write_irq_en('0);
        check_irq();
        clear_status(ZONES'(2));
        write_irq_en(ZONES'(3));
        check_irq();
        report_test("interrupt masking", err_mark);

        // random bounds, modes and samples
        err_mark = errors;
        for (int n = 0; n < RAND_SAMPLES; n++) begin
            if (n % 25 == 0) begin
                for (int z = 0; z < ZONES; z++) begin
                    r = lcg_next();
                    write_zone(z, r[7:0], r[15:8], r[17:16]);
                end
            end
            r = lcg_next();
            send_sample(r[31:30] != 2'b00, r[23:16]);
        end
        report_test("random stream", err_mark);

        // reset from a busy state with a live flag, status and irq
        err_mark = errors;
        write_zone(0, 8'h00, 8'h7f, 2'd1);
        write_irq_en(ZONES'(1));
        send_sample(1'b1, 8'h90);
        send_sample(1'b1, 8'h10);
        check_irq();
        @(posedge clk);
        #2;
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        clear_model();
        read_check(ZONE_CFG_BASE, cfg_word(0));
        read_check(IRQ_EN_ADDR, 32'(exp_irq_en));
        read_check(STATUS_ADDR, 32'(exp_status));
        read_check(FLAGS_ADDR, 32'(exp_flags));
        report_test("reset", err_mark);

        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, uut.u_assert.fail_count);
        if (errors == 0 && uut.u_assert.fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
